// ==== project.f ====
rtl/ppu_pkg.sv
rtl/ppu_cfg_if.sv
rtl/ppu_line_if.sv
rtl/ppu_regs.sv
rtl/ppu_video_timing.sv
rtl/ppu_vram.sv
rtl/ppu_bg_fetcher.sv
rtl/ppu_lcd_status.sv
rtl/ppu_top.sv
tests/ppu_tb.sv

// ==== tests/ppu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_tb;

    localparam int H_TOTAL = ppu_pkg::H_TOTAL_DEF;
    localparam int V_TOTAL = ppu_pkg::V_TOTAL_DEF;
    localparam int FRAME   = H_TOTAL * V_TOTAL;
    localparam int SIG_VS     = 0;
    localparam int SIG_VBLANK = 1;
    localparam int SIG_STAT   = 2;
    localparam int SIGNED_TILE_ZERO = 'h1000;   // Tile 0 sits at 9000 in 8800 mode

    logic               clk;
    logic               rst;
    ppu_pkg::cpu_addr_t a;
    ppu_pkg::byte_t     din;
    logic               wr;
    logic               vblank_ack;
    logic               stat_ack;
    ppu_pkg::byte_t     dout;
    logic               vblank_req;
    logic               stat_req;
    ppu_pkg::color_t    pixel;
    logic               valid;
    logic               hs;
    logic               vs;

    ppu_pkg::byte_t vram_model [8192];  // Mirror of what the CPU wrote
    logic [31:0]    lcg_state = 32'h1271_6bc7;
    int             checks = 0;
    int             errors = 0;
    int             cycle = 0;

    ppu_top #(
        .h_total (H_TOTAL),
        .v_total (V_TOTAL)
    ) dut (
        .clk, .rst, .a, .din, .wr, .vblank_ack, .stat_ack,
        .dout, .vblank_req, .stat_req, .pixel, .valid, .hs, .vs
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////
    // Checks and run control
    ////////////////////////////////////////
    task automatic check_byte(input string name, input ppu_pkg::byte_t got,
                              input ppu_pkg::byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_color(input string name, input ppu_pkg::color_t got,
                               input ppu_pkg::color_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic finish_run;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("Timeout at %0t while waiting for %s", $time, what);
        finish_run();
    endtask

    function automatic logic watched(input int which);
        case (which)
            SIG_VS:     return vs;
            SIG_VBLANK: return vblank_req;
            default:    return stat_req;
        endcase
    endfunction

    // Returns at the first falling edge where the signal is high
    task automatic wait_high(input int which, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!watched(which)) begin
            n++;
            if (n > limit)
                timed_out(what);
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////
    // Bus access and models
    ////////////////////////////////////////
    task automatic write_byte(input ppu_pkg::cpu_addr_t addr, input ppu_pkg::byte_t data);
        @(posedge clk);
        a   <= addr;
        din <= data;
        wr  <= 1'b1;
        @(posedge clk);
        wr  <= 1'b0;
    endtask

    // Address held two cycles so VRAM data has arrived
    task automatic read_byte(input ppu_pkg::cpu_addr_t addr, output ppu_pkg::byte_t data);
        @(posedge clk);
        a  <= addr;
        wr <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        data = dout;
    endtask

    task automatic pulse_ack(input logic v, input logic s);
        @(posedge clk);
        vblank_ack <= v;
        stat_ack   <= s;
        @(posedge clk);
        vblank_ack <= 1'b0;
        stat_ack   <= 1'b0;
        @(negedge clk);
    endtask

    function automatic ppu_pkg::byte_t next_rand;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];     // Upper bits are the better ones
    endfunction

    task automatic fill_vram;
        for (int i = 0; i < 8192; i++) begin
            vram_model[i] = next_rand();
            write_byte(ppu_pkg::cpu_addr_t'(ppu_pkg::VRAM_BASE + i), vram_model[i]);
        end
    endtask

    // Shade of one screen pixel from the map, tile and palette rules
    function automatic ppu_pkg::color_t expected_shade(input int ln, input int px,
            input ppu_pkg::byte_t lcdc, input ppu_pkg::byte_t scx,
            input ppu_pkg::byte_t scy, input ppu_pkg::byte_t bgp);
        int              y;
        int              x;
        int              map_off;
        int              tile;
        int              row_off;
        ppu_pkg::byte_t  lo;
        ppu_pkg::byte_t  hi;
        ppu_pkg::color_t idx;
        y = (ln + scy) % 256;
        x = (px + scx) % 256;
        map_off = (lcdc[3] ? ppu_pkg::MAP_BASE_HI : ppu_pkg::MAP_BASE_LO) + (y / 8) * 32 + x / 8;
        tile = vram_model[map_off];
        if (lcdc[4])
            row_off = tile * 16;
        else begin
            if (tile > 127)
                tile = tile - 256;   // Signed tile numbers
            row_off = SIGNED_TILE_ZERO + tile * 16;
        end
        row_off = row_off + (y % 8) * 2;
        lo  = vram_model[row_off];
        hi  = vram_model[row_off + 1];
        idx = {hi[7 - x % 8], lo[7 - x % 8]};
        if (!lcdc[0])
            idx = 2'd0;
        return bgp[2 * idx +: 2];
    endfunction

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic test_registers;
        ppu_pkg::byte_t d;
        read_byte(ppu_pkg::ADDR_LCDC, d);
        check_byte("LCDC after reset", d, 8'h00);
        read_byte(ppu_pkg::ADDR_BGP, d);
        check_byte("BGP after reset", d, ppu_pkg::BGP_RESET);
        read_byte(ppu_pkg::ADDR_STAT, d);
        check_byte("STAT after reset", d, {1'b1, 4'h0, 1'b1, ppu_pkg::VBLANK});  // LY equals LYC
        write_byte(ppu_pkg::ADDR_SCX, 8'h5A);
        write_byte(ppu_pkg::ADDR_SCY, 8'hA5);
        write_byte(ppu_pkg::ADDR_LYC, 8'h3C);
        write_byte(ppu_pkg::ADDR_BGP, 8'hE4);
        write_byte(ppu_pkg::ADDR_LY, 8'h77);
        read_byte(ppu_pkg::ADDR_SCX, d);
        check_byte("SCX", d, 8'h5A);
        read_byte(ppu_pkg::ADDR_SCY, d);
        check_byte("SCY", d, 8'hA5);
        read_byte(ppu_pkg::ADDR_LYC, d);
        check_byte("LYC", d, 8'h3C);
        read_byte(ppu_pkg::ADDR_BGP, d);
        check_byte("BGP", d, 8'hE4);
        read_byte(ppu_pkg::ADDR_LY, d);
        check_byte("LY after write", d, 8'h00);
        for (int i = 16'hFF46; i <= 16'hFF4B; i++) begin
            if (i != ppu_pkg::ADDR_BGP) begin
                read_byte(ppu_pkg::cpu_addr_t'(i), d);
                check_byte($sformatf("dropped register %h", i), d, 8'hFF);
            end
        end
    endtask

    task automatic test_vram_access;
        ppu_pkg::byte_t d;
        fill_vram();
        for (int i = 0; i < 8192; i++) begin
            read_byte(ppu_pkg::cpu_addr_t'(ppu_pkg::VRAM_BASE + i), d);
            check_byte($sformatf("VRAM %h", ppu_pkg::VRAM_BASE + i), d, vram_model[i]);
        end
    endtask

    task automatic test_vram_lockout;
        ppu_pkg::byte_t d;
        int             n;
        n = 0;
        write_byte(ppu_pkg::ADDR_LCDC, 8'h91);
        read_byte(ppu_pkg::ADDR_STAT, d);
        while (ppu_pkg::ppu_mode_e'(d[1:0]) != ppu_pkg::PIX_TRANS) begin
            n++;
            if (n > H_TOTAL)
                timed_out("mode PIX_TRANS");
            read_byte(ppu_pkg::ADDR_STAT, d);
        end
        read_byte(16'h8123, d);
        check_byte("VRAM read while drawing", d, 8'hFF);
        write_byte(16'h8123, ~vram_model['h123]);   // Must be dropped
        write_byte(ppu_pkg::ADDR_LCDC, 8'h00);
        read_byte(16'h8123, d);
        check_byte("VRAM after locked write", d, vram_model['h123]);
    endtask

    task automatic test_timing;
        int   nrise;
        int   vcnt;
        int   last;
        int   n;
        int   ln;
        logic hs_q;
        logic vs_q;
        logic done;
        write_byte(ppu_pkg::ADDR_LCDC, 8'h91);
        wait_high(SIG_VS, 2 * FRAME, "first vs");
        nrise = 0;
        vcnt  = 0;
        last  = cycle;
        n     = 0;
        hs_q  = hs;
        vs_q  = 1'b1;
        done  = 1'b0;
        // First hs after vs belongs to the last line of the frame
        while (!done) begin
            @(negedge clk);
            n++;
            if (n > 2 * FRAME)
                timed_out("second vs");
            if (hs && !hs_q) begin
                if (nrise > 0) begin
                    check_count("hs period", cycle - last, H_TOTAL);
                    ln = (nrise == 1) ? V_TOTAL - 1 : nrise - 2;
                    check_count($sformatf("valid pixels on line %0d", ln), vcnt,
                                (ln < ppu_pkg::V_ACTIVE) ? ppu_pkg::H_PIXELS : 0);
                end
                nrise++;
                last = cycle;
                vcnt = 0;
            end
            if (valid)
                vcnt++;
            if (vs && !vs_q) begin
                check_count("hs pulses per frame", nrise, V_TOTAL);
                done = 1'b1;
            end
            hs_q = hs;
            vs_q = vs;
        end
    endtask

    task automatic test_frame(input ppu_pkg::byte_t lcdc, input ppu_pkg::byte_t scx,
                              input ppu_pkg::byte_t scy, input ppu_pkg::byte_t bgp);
        int n;
        int k;
        write_byte(ppu_pkg::ADDR_LCDC, 8'h00);
        fill_vram();
        write_byte(ppu_pkg::ADDR_SCX, scx);
        write_byte(ppu_pkg::ADDR_SCY, scy);
        write_byte(ppu_pkg::ADDR_BGP, bgp);
        write_byte(ppu_pkg::ADDR_LCDC, lcdc);   // Frame starts at line 0
        n = 0;
        k = 0;
        while (k < ppu_pkg::V_ACTIVE * ppu_pkg::H_PIXELS) begin
            @(negedge clk);
            n++;
            if (n > 2 * FRAME)
                timed_out("frame pixels");
            if (valid) begin
                check_color($sformatf("pixel (%0d,%0d)", k / ppu_pkg::H_PIXELS,
                            k % ppu_pkg::H_PIXELS), pixel,
                            expected_shade(k / ppu_pkg::H_PIXELS, k % ppu_pkg::H_PIXELS,
                                           lcdc, scx, scy, bgp));
                k++;
            end
        end
    endtask

    task automatic test_interrupts;
        ppu_pkg::byte_t d;
        int             first;
        write_byte(ppu_pkg::ADDR_LCDC, 8'h00);
        write_byte(ppu_pkg::ADDR_LYC, 8'd40);
        write_byte(ppu_pkg::ADDR_STAT, 8'h40);   // LYC source only
        pulse_ack(1'b1, 1'b1);
        write_byte(ppu_pkg::ADDR_LCDC, 8'h91);
        wait_high(SIG_STAT, FRAME, "stat_req on LYC");
        read_byte(ppu_pkg::ADDR_LY, d);
        check_byte("LY at LYC interrupt", d, 8'd40);
        read_byte(ppu_pkg::ADDR_STAT, d);
        check_flag("STAT bit 2", d[2], 1'b1);
        pulse_ack(1'b0, 1'b1);
        check_flag("stat_req after ack", stat_req, 1'b0);
        write_byte(ppu_pkg::ADDR_STAT, 8'h48);   // Add HBLANK source
        wait_high(SIG_STAT, 2 * H_TOTAL, "stat_req on HBLANK");
        read_byte(ppu_pkg::ADDR_STAT, d);
        check_byte("STAT mode at HBLANK interrupt", {6'd0, d[1:0]}, {6'd0, ppu_pkg::HBLANK});
        write_byte(ppu_pkg::ADDR_STAT, 8'h00);
        pulse_ack(1'b0, 1'b1);
        // V-blank request period
        wait_high(SIG_VBLANK, FRAME, "first vblank_req");
        first = cycle;
        pulse_ack(1'b1, 1'b0);
        check_flag("vblank_req after ack", vblank_req, 1'b0);
        wait_high(SIG_VBLANK, 2 * FRAME, "second vblank_req");
        check_count("vblank_req period", cycle - first, FRAME);
        pulse_ack(1'b1, 1'b0);
    endtask

    initial begin
        rst        = 1'b1;
        a          = '0;
        din        = '0;
        wr         = 1'b0;
        vblank_ack = 1'b0;
        stat_ack   = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_registers();
        test_vram_access();
        test_vram_lockout();
        test_timing();
        test_frame(8'h91, 8'h2D, 8'h93, 8'h1B);   // 8000 tiles, low map
        test_frame(8'h89, 8'hF3, 8'h6E, 8'hD2);   // 8800 tiles, high map
        test_frame(8'h90, 8'h15, 8'h27, 8'h1E);   // Background disabled
        test_interrupts();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== rtl/ppu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_top #(
    parameter int h_total = ppu_pkg::H_TOTAL_DEF,
    parameter int v_total = ppu_pkg::V_TOTAL_DEF
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire ppu_pkg::cpu_addr_t a,
    input  wire ppu_pkg::byte_t     din,
    input  wire logic               wr,
    input  wire logic               vblank_ack,
    input  wire logic               stat_ack,
    output ppu_pkg::byte_t          dout,
    output logic                    vblank_req,
    output logic                    stat_req,
    output ppu_pkg::color_t         pixel,
    output logic                    valid,
    output logic                    hs,
    output logic                    vs
);

    logic                drawing;
    ppu_pkg::vram_addr_t fetch_addr;
    ppu_pkg::byte_t      vram_rd_data;
    ppu_pkg::ppu_mode_e  mode;
    logic                coincidence;
    logic [3:0]          stat_enables;
    ppu_pkg::byte_t      lyc;

    ppu_cfg_if  cfg_bus ();
    ppu_line_if line_bus ();

    ppu_regs u_regs (
        .clk, .rst, .a, .din, .wr,
        .vram_rd_data, .drawing,
        .ly (line_bus.ly),
        .mode, .coincidence, .dout, .stat_enables, .lyc,
        .cfg (cfg_bus.regs)
    );

    ppu_video_timing #(
        .h_total (h_total),
        .v_total (v_total)
    ) u_timing (
        .clk, .rst,
        .lcd_en (cfg_bus.lcd_en),
        .hs, .vs,
        .line (line_bus.timing)
    );

    ppu_vram u_vram (
        .clk, .a, .din, .wr, .drawing, .fetch_addr,
        .rd_data (vram_rd_data)
    );

    ppu_bg_fetcher u_fetcher (
        .clk, .rst,
        .cfg  (cfg_bus.fetcher),
        .line (line_bus.fetcher),
        .rd_data (vram_rd_data),
        .fetch_addr, .drawing, .pixel, .valid
    );

    ppu_lcd_status u_status (
        .clk, .rst,
        .lcd_en (cfg_bus.lcd_en),
        .line (line_bus.status),
        .drawing, .stat_enables, .lyc, .vblank_ack, .stat_ack,
        .mode, .coincidence, .vblank_req, .stat_req
    );

endmodule

`default_nettype wire

// ==== rtl/ppu_lcd_status.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_lcd_status (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           lcd_en,
    ppu_line_if.status          line,
    input  wire logic           drawing,
    input  wire logic [3:0]     stat_enables,   // STAT bits 6 to 3
    input  wire ppu_pkg::byte_t lyc,
    input  wire logic           vblank_ack,
    input  wire logic           stat_ack,
    output ppu_pkg::ppu_mode_e  mode,
    output logic                coincidence,
    output logic                vblank_req,
    output logic                stat_req
);

    ppu_pkg::ppu_mode_e next_mode;
    logic               entering;
    logic               lyc_hit;
    logic               vblank_set;
    logic               stat_set;

    always_comb begin
        if (!lcd_en || line.in_vblank)
            next_mode = ppu_pkg::VBLANK;
        else if (line.oam_phase)
            next_mode = ppu_pkg::OAM_SEARCH;
        else if (drawing)
            next_mode = ppu_pkg::PIX_TRANS;
        else
            next_mode = ppu_pkg::HBLANK;
    end

    assign entering   = next_mode != mode;
    assign lyc_hit    = line.ly == lyc;
    assign vblank_set = entering && (next_mode == ppu_pkg::VBLANK);

    // STAT sources, each on its rising condition only
    assign stat_set = (stat_enables[3] && lyc_hit && !coincidence) ||
                      (entering && stat_enables[0] && next_mode == ppu_pkg::HBLANK) ||
                      (entering && stat_enables[1] && next_mode == ppu_pkg::VBLANK) ||
                      (entering && stat_enables[2] && next_mode == ppu_pkg::OAM_SEARCH);

    always_ff @(posedge clk) begin
        if (rst) begin
            mode        <= ppu_pkg::VBLANK;
            coincidence <= 1'b0;
            vblank_req  <= 1'b0;
            stat_req    <= 1'b0;
        end else begin
            mode        <= next_mode;
            coincidence <= lyc_hit;
            vblank_req  <= !vblank_ack && (vblank_req || vblank_set);   // Ack wins
            stat_req    <= !stat_ack && (stat_req || stat_set);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ppu_bg_fetcher.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_bg_fetcher (
    input  wire logic            clk,
    input  wire logic            rst,
    ppu_cfg_if.fetcher           cfg,
    ppu_line_if.fetcher          line,
    input  wire ppu_pkg::byte_t  rd_data,
    output ppu_pkg::vram_addr_t  fetch_addr,
    output logic                 drawing,
    output ppu_pkg::color_t      pixel,
    output logic                 valid
);

    ppu_pkg::fetch_state_e state;
    logic                  busy;
    logic [4:0]            fifo_cnt;
    ppu_pkg::color_t       fifo [16];       // Entry 0 is the next pixel out
    ppu_pkg::color_t       fifo_next [16];
    logic [4:0]            level;
    logic [4:0]            tile_x;
    logic [2:0]            drop_cnt;
    ppu_pkg::byte_t        pix_cnt;
    ppu_pkg::byte_t        tile_id;
    ppu_pkg::byte_t        tile_adj;
    ppu_pkg::byte_t        data0;
    ppu_pkg::byte_t        data1;
    ppu_pkg::byte_t        map_y;
    ppu_pkg::vram_addr_t   map_addr;
    ppu_pkg::vram_addr_t   tile_addr;
    ppu_pkg::color_t       head;
    logic                  plane;
    logic                  shift;
    logic                  push;
    logic                  last;

    assign drawing = busy | line.draw_start;

    ////////////////////////////////////////
    // Fetch addresses
    ////////////////////////////////////////
    assign map_y    = line.ly + cfg.scy;
    assign map_addr = (cfg.bg_map_sel ? ppu_pkg::MAP_BASE_HI : ppu_pkg::MAP_BASE_LO) +
                      ppu_pkg::vram_addr_t'({map_y[7:3], tile_x});

    // 8800 mode flips the sign bit so tile 0 sits at 9000
    assign tile_adj  = {~(cfg.tile_data_sel ^ tile_id[7]), tile_id[6:0]};
    assign plane     = state inside {ppu_pkg::DATA1_A, ppu_pkg::DATA1_B};
    assign tile_addr = (cfg.tile_data_sel ? ppu_pkg::TILE_BASE_HI : ppu_pkg::TILE_BASE_LO) +
                       ppu_pkg::vram_addr_t'({tile_adj, map_y[2:0], plane});

    assign fetch_addr = (state inside {ppu_pkg::DATA0_A, ppu_pkg::DATA0_B,
                                       ppu_pkg::DATA1_A, ppu_pkg::DATA1_B}) ?
                        tile_addr : map_addr;

    ////////////////////////////////////////
    // Pixel FIFO
    ////////////////////////////////////////
    assign shift = busy && (fifo_cnt > 5'd8);
    assign level = fifo_cnt - 5'(shift);
    assign push  = (state == ppu_pkg::WAIT_B) && (level <= 5'd8);
    assign last  = shift && (drop_cnt == 3'd0) &&
                   (pix_cnt == 8'(ppu_pkg::H_PIXELS - 1));
    assign head  = cfg.bg_en ? fifo[0] : 2'd0;

    always_comb begin
        fifo_next = fifo;
        if (shift) begin
            for (int i = 0; i < 15; i++)
                fifo_next[i] = fifo[i + 1];
        end
        if (push) begin
            // New tile lands behind what is left, leftmost pixel first
            for (int j = 0; j < 8; j++)
                fifo_next[level + j] = {data1[7 - j], data0[7 - j]};
        end
    end

    ////////////////////////////////////////
    // Fetch FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || !cfg.lcd_en) begin
            state    <= ppu_pkg::IDLE;
            busy     <= 1'b0;
            fifo_cnt <= '0;
            valid    <= 1'b0;
        end else begin
            valid    <= shift && (drop_cnt == 3'd0);
            fifo_cnt <= level + (push ? 5'd8 : 5'd0);
            if (shift && drop_cnt != 3'd0)
                drop_cnt <= drop_cnt - 3'd1;     // Fine scroll
            if (shift && drop_cnt == 3'd0)
                pix_cnt <= pix_cnt + 8'd1;
            case (state)
                ppu_pkg::IDLE: begin
                    if (line.draw_start) begin
                        state    <= ppu_pkg::TILE_ID_A;
                        busy     <= 1'b1;
                        tile_x   <= cfg.scx[7:3];
                        drop_cnt <= cfg.scx[2:0];
                        pix_cnt  <= '0;
                    end
                end
                ppu_pkg::TILE_ID_A: state <= ppu_pkg::TILE_ID_B;
                ppu_pkg::TILE_ID_B: begin
                    state  <= ppu_pkg::DATA0_A;
                    tile_x <= tile_x + 5'd1;     // Map address already taken
                end
                ppu_pkg::DATA0_A:   state <= ppu_pkg::DATA0_B;
                ppu_pkg::DATA0_B:   state <= ppu_pkg::DATA1_A;
                ppu_pkg::DATA1_A:   state <= ppu_pkg::DATA1_B;
                ppu_pkg::DATA1_B:   state <= ppu_pkg::WAIT_A;
                ppu_pkg::WAIT_A:    state <= ppu_pkg::WAIT_B;
                ppu_pkg::WAIT_B:    if (push) state <= ppu_pkg::TILE_ID_A;
                default:            state <= ppu_pkg::IDLE;
            endcase
            if (last) begin
                state    <= ppu_pkg::IDLE;
                busy     <= 1'b0;
                fifo_cnt <= '0;
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        fifo <= fifo_next;
        if (state == ppu_pkg::TILE_ID_B)
            tile_id <= rd_data;
        if (state == ppu_pkg::DATA0_B)
            data0 <= rd_data;
        if (state == ppu_pkg::DATA1_B)
            data1 <= rd_data;
        pixel <= cfg.bgp[{head, 1'b0} +: 2];     // Palette lookup
    end

endmodule

`default_nettype wire

// ==== rtl/ppu_vram.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_vram (
    input  wire logic                clk,
    input  wire ppu_pkg::cpu_addr_t  a,
    input  wire ppu_pkg::byte_t      din,
    input  wire logic                wr,
    input  wire logic                drawing,
    input  wire ppu_pkg::vram_addr_t fetch_addr,
    output ppu_pkg::byte_t           rd_data
);

    ppu_pkg::byte_t     mem [8192];
    ppu_pkg::vram_addr_t addr;
    logic               in_vram;
    logic               we;

    assign in_vram = (a >= ppu_pkg::VRAM_BASE) && (a <= ppu_pkg::VRAM_LAST);

    // Fetcher owns the port during pixel transfer
    assign addr = drawing ? fetch_addr : a[12:0];
    assign we   = wr && in_vram && !drawing;

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= din;
        rd_data <= mem[addr];   // One cycle read latency
    end

endmodule

`default_nettype wire

// ==== rtl/ppu_video_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_video_timing #(
    parameter int h_total = ppu_pkg::H_TOTAL_DEF,
    parameter int v_total = ppu_pkg::V_TOTAL_DEF
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic lcd_en,
    output logic      hs,
    output logic      vs,
    ppu_line_if.timing line
);

    localparam int HW = $clog2(h_total);

    logic [HW-1:0]  h_count;
    ppu_pkg::byte_t v_count;
    logic           vblank;
    logic           visible;

    // Dot and line counters, parked at zero while the LCD is off
    always_ff @(posedge clk) begin
        if (rst || !lcd_en) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == HW'(h_total - 1)) begin
            h_count <= '0;
            if (v_count == 8'(v_total - 1))
                v_count <= '0;
            else
                v_count <= v_count + 8'd1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign vblank  = v_count >= ppu_pkg::V_ACTIVE;
    assign visible = lcd_en && !vblank;

    // Sync strobes
    assign hs = lcd_en && (h_count >= ppu_pkg::H_FRONT) &&
                (h_count < ppu_pkg::H_FRONT + ppu_pkg::H_SYNC);
    assign vs = lcd_en && (v_count >= ppu_pkg::V_ACTIVE + ppu_pkg::V_BACK) &&
                (v_count < ppu_pkg::V_ACTIVE + ppu_pkg::V_BACK + ppu_pkg::V_SYNC);

    assign line.ly         = v_count;
    assign line.in_vblank  = vblank;
    assign line.oam_phase  = visible && (h_count < ppu_pkg::OAM_CYCLES);
    assign line.draw_start = visible && (h_count == ppu_pkg::OAM_CYCLES);

endmodule

`default_nettype wire

// ==== rtl/ppu_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_regs (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire ppu_pkg::cpu_addr_t a,
    input  wire ppu_pkg::byte_t     din,
    input  wire logic               wr,
    input  wire ppu_pkg::byte_t     vram_rd_data,
    input  wire logic               drawing,
    input  wire ppu_pkg::byte_t     ly,
    input  wire ppu_pkg::ppu_mode_e mode,
    input  wire logic               coincidence,
    output ppu_pkg::byte_t          dout,
    output logic [3:0]              stat_enables,
    output ppu_pkg::byte_t          lyc,
    ppu_cfg_if.regs                 cfg
);

    ppu_pkg::byte_t lcdc;
    ppu_pkg::byte_t scy;
    ppu_pkg::byte_t scx;
    ppu_pkg::byte_t bgp;
    logic           in_vram;

    assign in_vram = (a >= ppu_pkg::VRAM_BASE) && (a <= ppu_pkg::VRAM_LAST);

    ////////////////////////////////////////
    // CPU writes
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc         <= 8'h00;       // LCD off
            stat_enables <= 4'h0;
            scy          <= 8'h00;
            scx          <= 8'h00;
            lyc          <= 8'h00;
            bgp          <= ppu_pkg::BGP_RESET;
        end else if (wr) begin
            case (a)
                ppu_pkg::ADDR_LCDC: lcdc <= din;
                ppu_pkg::ADDR_STAT: stat_enables <= din[6:3];  // Only the enables are writable
                ppu_pkg::ADDR_SCY:  scy <= din;
                ppu_pkg::ADDR_SCX:  scx <= din;
                ppu_pkg::ADDR_LYC:  lyc <= din;
                ppu_pkg::ADDR_BGP:  bgp <= din;
                default: ;                   // LY is read only
            endcase
        end
    end

    ////////////////////////////////////////
    // CPU reads
    ////////////////////////////////////////
    always_comb begin
        dout = 8'hFF;
        case (a)
            ppu_pkg::ADDR_LCDC: dout = lcdc;
            ppu_pkg::ADDR_STAT: dout = {1'b1, stat_enables, coincidence, mode};
            ppu_pkg::ADDR_SCY:  dout = scy;
            ppu_pkg::ADDR_SCX:  dout = scx;
            ppu_pkg::ADDR_LY:   dout = ly;
            ppu_pkg::ADDR_LYC:  dout = lyc;
            ppu_pkg::ADDR_BGP:  dout = bgp;
            default: begin
                // VRAM is locked out while the fetcher owns it
                if (in_vram && !drawing)
                    dout = vram_rd_data;
            end
        endcase
    end

    // LCDC fields
    assign cfg.lcd_en        = lcdc[7];
    assign cfg.tile_data_sel = lcdc[4];
    assign cfg.bg_map_sel    = lcdc[3];
    assign cfg.bg_en         = lcdc[0];
    assign cfg.scx           = scx;
    assign cfg.scy           = scy;
    assign cfg.bgp           = bgp;

endmodule

`default_nettype wire

// ==== rtl/ppu_line_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Line position from the video timing
interface ppu_line_if;
    ppu_pkg::byte_t ly;
    logic           in_vblank;
    logic           oam_phase;
    logic           draw_start;  // One cycle at h count OAM_CYCLES

    modport timing (
        output ly, in_vblank, oam_phase, draw_start
    );

    modport fetcher (
        input draw_start, ly
    );

    modport status (
        input ly, in_vblank, oam_phase
    );
endinterface

`default_nettype wire

// ==== rtl/ppu_cfg_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Control fields decoded from LCDC plus scroll and palette
interface ppu_cfg_if;
    logic          lcd_en;
    logic          bg_en;
    logic          bg_map_sel;      // 1 selects the 9C00 map
    logic          tile_data_sel;   // 1 selects 8000 tile data
    ppu_pkg::byte_t scx;
    ppu_pkg::byte_t scy;
    ppu_pkg::byte_t bgp;

    modport regs (
        output lcd_en, bg_en, bg_map_sel, tile_data_sel, scx, scy, bgp
    );

    modport fetcher (
        input lcd_en, bg_en, bg_map_sel, tile_data_sel, scx, scy, bgp
    );
endinterface

`default_nettype wire

// ==== rtl/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [12:0] vram_addr_t;
    typedef logic [1:0]  color_t;    // Color index or shade

    typedef enum logic [1:0] {
        HBLANK     = 2'd0,
        VBLANK     = 2'd1,
        OAM_SEARCH = 2'd2,
        PIX_TRANS  = 2'd3
    } ppu_mode_e;

    // Each fetch stage is an address cycle (A) and a data cycle (B)
    typedef enum logic [3:0] {
        IDLE, TILE_ID_A, TILE_ID_B, DATA0_A, DATA0_B, DATA1_A, DATA1_B, WAIT_A, WAIT_B
    } fetch_state_e;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////
    localparam cpu_addr_t ADDR_LCDC = 16'hFF40;
    localparam cpu_addr_t ADDR_STAT = 16'hFF41;
    localparam cpu_addr_t ADDR_SCY  = 16'hFF42;
    localparam cpu_addr_t ADDR_SCX  = 16'hFF43;
    localparam cpu_addr_t ADDR_LY   = 16'hFF44;
    localparam cpu_addr_t ADDR_LYC  = 16'hFF45;
    localparam cpu_addr_t ADDR_BGP  = 16'hFF47;

    localparam cpu_addr_t VRAM_BASE = 16'h8000;
    localparam cpu_addr_t VRAM_LAST = 16'h9FFF;

    localparam vram_addr_t MAP_BASE_LO  = 13'h1800;   // 9800
    localparam vram_addr_t MAP_BASE_HI  = 13'h1C00;   // 9C00
    localparam vram_addr_t TILE_BASE_LO = 13'h0800;   // 8800, signed tile numbers
    localparam vram_addr_t TILE_BASE_HI = 13'h0000;   // 8000, unsigned

    ////////////////////////////////////////
    // Line and frame timing
    ////////////////////////////////////////
    localparam int H_TOTAL_DEF = 456;
    localparam int V_TOTAL_DEF = 154;
    localparam int V_ACTIVE    = 144;
    localparam int H_PIXELS    = 160;
    localparam int OAM_CYCLES  = 80;
    localparam int H_FRONT     = 76;
    localparam int H_SYNC      = 4;
    localparam int V_BACK      = 9;
    localparam int V_SYNC      = 1;

    localparam byte_t BGP_RESET = 8'hFC;

endpackage

`default_nettype wire
